/* Bender.yml */
package:
  name: eeg_fir_filter

sources:
  - files:
      - eegFirPkg.sv
      - firIngress.sv
      - firTap.sv
      - firEgress.sv
      - eegFirFilter.sv
  - target: test
    files:
      - eegFirFilter_assertions.sv
      - eegFirFilter_tb.sv

/* eegFirFilter.sv */
// Top level of the streaming EEG FIR low-pass filter; one sample in and one sum out per beat.
`default_nettype none
`timescale 1ns/1ps

module eegFirFilter #(
    parameter eegFirPkg::weightArray_t Weights = eegFirPkg::DefaultWeights
) (
    input logic clk,
    input logic reset,
    input eegFirPkg::sampleBeat_t sampleIn,
    output eegFirPkg::filterBeat_t filterOut
);

    import eegFirPkg::*;

    sample_t tapSample;
    logic productStrobe;
    logic sumStrobe;

    // Entry k is the output of tap k.
    // Entry NumTaps feeds the last tap.
    acc_t partialChain [0:NumTaps];

    // ==========================================================
    // Ingress
    // ==========================================================

    firIngress uIngress (
        .clk(clk),
        .reset(reset),
        .sampleIn(sampleIn),
        .tapSample(tapSample),
        .productStrobe(productStrobe),
        .sumStrobe(sumStrobe)
    );

    // ==========================================================
    // Tap chain
    // ==========================================================

    // Nothing precedes the last tap.
    assign partialChain[NumTaps] = '0;

    // Sums flow from the last tap down to tap 0.
    for (genvar k = 0; k < NumTaps; k++)
    begin : gTap
        firTap #(
            .Weight(Weights[k])
        ) uTap (
            .clk(clk),
            .reset(reset),
            .tapSample(tapSample),
            .productStrobe(productStrobe),
            .sumStrobe(sumStrobe),
            .partialIn(partialChain[k+1]),
            .partialOut(partialChain[k])
        );
    end

    // ==========================================================
    // Egress
    // ==========================================================

    firEgress #(
        .NumTaps(NumTaps)
    ) uEgress (
        .clk(clk),
        .reset(reset),
        .sumStrobe(sumStrobe),
        .partialOut(partialChain[0]),
        .filterOut(filterOut)
    );

endmodule

`default_nettype wire

/* eegFirFilter_assertions.sv */
// Protocol assertions for the EEG FIR filter top level; bound to eegFirFilter by the bind below.
`default_nettype none
`timescale 1ns/1ps

module eegFirFilter_assertions (
    input logic clk,
    input logic reset,
    input eegFirPkg::sampleBeat_t sampleIn,
    input eegFirPkg::filterBeat_t filterOut
);

    // Edges between the sampled input beat and the sampled output beat.
    localparam int BeatDelay = 4;

    // ==========================================================
    // Output valid
    // ==========================================================

    validLowInReset : assert property (@(posedge clk) reset |=> !filterOut.valid)
        else $error("filterOut.valid high after a reset edge");

    // Every accepted sample produces one output.
    outputForEverySample : assert property (
        @(posedge clk) disable iff (reset)
        sampleIn.valid |-> ##BeatDelay filterOut.valid
    ) else $error("accepted sample produced no output");

    // No output without a sample behind it.
    noOrphanOutput : assert property (
        @(posedge clk) disable iff (reset)
        filterOut.valid |-> $past(sampleIn.valid, BeatDelay)
    ) else $error("filterOut.valid with no sample accepted before it");

    // ==========================================================
    // Settled flag
    // ==========================================================

    settledStaysHigh : assert property (
        @(posedge clk) disable iff (reset)
        filterOut.settled |=> filterOut.settled
    ) else $error("filterOut.settled fell without a reset");

endmodule

bind eegFirFilter eegFirFilter_assertions uAssertions (
    .clk(clk),
    .reset(reset),
    .sampleIn(sampleIn),
    .filterOut(filterOut)
);

`default_nettype wire

/* eegFirFilter_tb.sv */
// Self-checking testbench for the EEG FIR filter; run as top module eegFirFilter_tb.
`default_nettype none
`timescale 1ns/1ps

module eegFirFilter_tb;

    import eegFirPkg::*;

    localparam int ResetCycles = 16;
    localparam int RandomBeats = 400;
    localparam int SettleBeats = 30;
    localparam int FullScaleRun = 40;
    localparam int GapPercent = 30;
    localparam int LatencyEdges = 4;
    localparam int unsigned Seed = 32'h88d1_8637;

    // Roughly 900 cycles of stimulus, gaps, drains and resets.
    localparam int TimeoutCycles = 4000;

    logic clk;
    logic reset;
    sampleBeat_t sampleIn;
    filterBeat_t filterOut;

    sample_t history [$];
    filterBeat_t expectQ [$];
    int acceptEdges [$];
    filterBeat_t nextExpected;
    int acceptEdge;
    int edgeCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testStartErrors = 0;
    int sent;

    eegFirFilter uut (
        .clk(clk),
        .reset(reset),
        .sampleIn(sampleIn),
        .filterOut(filterOut)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==========================================================
    // Reference model
    // ==========================================================

    // Output for the sample at index newest of the history.
    // Samples before reset count as zero.
    function automatic filterBeat_t referenceBeat(input int newest);
        filterBeat_t beat;
        longint total;
        int idx;
        total = 0;
        for (int k = 0; k < NumTaps; k++)
        begin
            idx = newest - k;
            if (idx >= 0)
            begin
                total += longint'(DefaultWeights[k]) * longint'(history[idx]);
            end
        end
        beat.valid = 1'b1;
        beat.settled = (newest + 1 >= NumTaps);
        beat.sum = acc_t'(total);
        return beat;
    endfunction

    // ==========================================================
    // Checks
    // ==========================================================

    task automatic checkSum(input string name, input acc_t got, input acc_t expected);
        checkCount++;
        if (got !== expected)
        begin
            errorCount++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        checkCount++;
        if (got !== expected)
        begin
            errorCount++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    // Edge counter, accept log and run limit.
    always @(posedge clk)
    begin
        edgeCount++;
        if (!reset && sampleIn.valid)
        begin
            acceptEdges.push_back(edgeCount);
        end
        if (edgeCount >= TimeoutCycles)
        begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Value and settled flag of every output beat.
    always @(negedge clk)
    begin
        if (!reset && filterOut.valid)
        begin
            if (expectQ.size() == 0)
            begin
                errorCount++;
                $display("Output beat appeared with no sample in flight");
            end
            else
            begin
                nextExpected = expectQ.pop_front();
                checkSum("filterOut.sum", filterOut.sum, nextExpected.sum);
                checkFlag("filterOut.settled", filterOut.settled, nextExpected.settled);
            end
        end
    end

    // Latency from the accepting edge.
    // The sink takes a beat on the rising edge after it is loaded.
    always @(negedge clk)
    begin
        if (!reset && filterOut.valid && acceptEdges.size() != 0)
        begin
            acceptEdge = acceptEdges.pop_front();
            checkCount++;
            if (edgeCount + 1 - acceptEdge != LatencyEdges)
            begin
                errorCount++;
                $display("Output arrived %0d edges after its sample instead of %0d",
                    edgeCount + 1 - acceptEdge, LatencyEdges);
            end
        end
    end

    // ==========================================================
    // Stimulus helpers
    // ==========================================================

    task automatic driveSample(input logic valid, input sample_t value);
        @(negedge clk);
        sampleIn.valid = valid;
        sampleIn.sample = value;
        if (valid)
        begin
            history.push_back(value);
            expectQ.push_back(referenceBeat(history.size() - 1));
        end
    endtask

    task automatic drainPipeline();
        @(negedge clk);
        sampleIn = '0;
        while (expectQ.size() != 0)
        begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // Output stays quiet while reset is held.
    task automatic applyReset();
        @(negedge clk);
        reset = 1'b1;
        sampleIn = '0;
        history.delete();
        expectQ.delete();
        acceptEdges.delete();
        repeat (ResetCycles)
        begin
            @(negedge clk);
            checkFlag("filterOut.valid", filterOut.valid, 1'b0);
            checkFlag("filterOut.settled", filterOut.settled, 1'b0);
        end
        reset = 1'b0;
    endtask

    task automatic finishTest(input string name, input int beats);
        $display("test %s: %0d samples, %0d errors", name, beats,
            errorCount - testStartErrors);
        testStartErrors = errorCount;
    endtask

    // ==========================================================
    // Tests
    // ==========================================================

    initial
    begin
        reset = 1'b1;
        sampleIn = '0;
        void'($urandom(Seed));

        applyReset();
        repeat (8)
        begin
            @(negedge clk);
            checkFlag("filterOut.valid", filterOut.valid, 1'b0);
            checkFlag("filterOut.settled", filterOut.settled, 1'b0);
        end
        finishTest("1 reset state", 0);

        // Outputs walk through the weights one by one.
        driveSample(1'b1, sample_t'(1));
        repeat (NumTaps - 1)
        begin
            driveSample(1'b1, sample_t'(0));
        end
        drainPipeline();
        finishTest("2 impulse response", NumTaps);

        sent = 0;
        while (sent < RandomBeats)
        begin
            if (($urandom % 100) < GapPercent)
            begin
                driveSample(1'b0, sample_t'($urandom));
            end
            else
            begin
                driveSample(1'b1, sample_t'($urandom));
                sent++;
            end
        end
        drainPipeline();
        finishTest("3 random stream with gaps", RandomBeats);

        applyReset();
        for (int i = 0; i < SettleBeats; i++)
        begin
            driveSample(1'b1, sample_t'($urandom));
        end
        drainPipeline();
        finishTest("4 settled flag", SettleBeats);

        repeat (FullScaleRun)
        begin
            driveSample(1'b1, sample_t'(-2048));
        end
        repeat (FullScaleRun)
        begin
            driveSample(1'b1, sample_t'(2047));
        end
        for (int i = 0; i < FullScaleRun; i++)
        begin
            driveSample(1'b1, (i % 2 == 0) ? sample_t'(2047) : sample_t'(-2048));
        end
        drainPipeline();
        finishTest("5 full scale", 3 * FullScaleRun);

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* eegFirPkg.sv */
// Shared types, widths and default weights for the EEG FIR filter; compile before any module.
`default_nettype none

package eegFirPkg;

    // ==========================================================
    // Arithmetic widths
    // ==========================================================

    localparam int SampleWidth = 12;
    localparam int WeightWidth = 12;
    localparam int ProductWidth = SampleWidth + WeightWidth;

    // Headroom for the sum of all 17 products.
    localparam int AccWidth = 29;

    localparam int NumTaps = 17;

    typedef logic signed [SampleWidth-1:0] sample_t;
    typedef logic signed [WeightWidth-1:0] weight_t;
    typedef logic signed [ProductWidth-1:0] product_t;
    typedef logic signed [AccWidth-1:0] acc_t;

    // Element k holds the weight of tap k.
    typedef weight_t [NumTaps-1:0] weightArray_t;

    // ==========================================================
    // Low-pass weights
    // ==========================================================

    // Symmetric about tap 8.
    localparam weightArray_t DefaultWeights = {
        weight_t'(-5),
        weight_t'(-30),
        weight_t'(-86),
        weight_t'(-151),
        weight_t'(-157),
        weight_t'(-41),
        weight_t'(45),
        weight_t'(404),
        weight_t'(249),
        weight_t'(404),
        weight_t'(45),
        weight_t'(-41),
        weight_t'(-157),
        weight_t'(-151),
        weight_t'(-86),
        weight_t'(-30),
        weight_t'(-5)
    };

    // ==========================================================
    // Stream beats
    // ==========================================================

    // Input beat, one EEG sample.
    typedef struct packed {
        logic valid;
        sample_t sample;
    } sampleBeat_t;

    // Output beat.
    // settled is high once the window holds no reset zeros.
    typedef struct packed {
        logic valid;
        logic settled;
        acc_t sum;
    } filterBeat_t;

endpackage

`default_nettype wire

/* firEgress.sv */
// Output stage of the FIR filter; registers the final sum and flags a filled window.
`default_nettype none
`timescale 1ns/1ps

module firEgress #(
    parameter int NumTaps = 17
) (
    input logic clk,
    input logic reset,
    input logic sumStrobe,
    input eegFirPkg::acc_t partialOut,
    output eegFirPkg::filterBeat_t filterOut
);

    localparam int CountWidth = $clog2(NumTaps + 1);

    logic [CountWidth-1:0] outCount;
    logic [CountWidth-1:0] countNext;
    logic sumDone;
    logic outValid;
    logic [$bits(partialOut)-1:0] outSum;

    // ==========================================================
    // Window fill counter
    // ==========================================================

    // Saturates at NumTaps.
    always_comb
    begin
        if (sumDone && (outCount != CountWidth'(NumTaps)))
        begin
            countNext = outCount + 1'b1;
        end
        else
        begin
            countNext = outCount;
        end
    end

    // Tap 0 loads its sum on sumStrobe.
    // The finished sum is taken one edge later.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sumDone <= 1'b0;
            outCount <= '0;
            outValid <= 1'b0;
        end
        else
        begin
            sumDone <= sumStrobe;
            outCount <= countNext;
            outValid <= sumDone;
        end
    end

    // Last sum stays visible through gaps.
    always_ff @(posedge clk)
    begin
        if (sumDone)
        begin
            outSum <= partialOut;
        end
    end

    assign filterOut.valid = outValid;
    // High from the NumTaps-th output on.
    assign filterOut.settled = (outCount == CountWidth'(NumTaps));
    assign filterOut.sum = outSum;

endmodule

`default_nettype wire

/* firIngress.sv */
// Input stage of the FIR filter; latches each sample beat and paces the tap pipeline.
`default_nettype none
`timescale 1ns/1ps

module firIngress (
    input logic clk,
    input logic reset,
    input eegFirPkg::sampleBeat_t sampleIn,
    output eegFirPkg::sample_t tapSample,
    output logic productStrobe,
    output logic sumStrobe
);

    // ==========================================================
    // Sample register
    // ==========================================================

    // Held across input gaps.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tapSample <= '0;
        end
        else if (sampleIn.valid)
        begin
            tapSample <= sampleIn.sample;
        end
    end

    // ==========================================================
    // Strobes
    // ==========================================================

    // Product stage fires the cycle after a sample lands.
    // Sum stage fires one cycle after that.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            productStrobe <= 1'b0;
            sumStrobe <= 1'b0;
        end
        else
        begin
            productStrobe <= sampleIn.valid;
            sumStrobe <= productStrobe;
        end
    end

endmodule

`default_nettype wire

/* firTap.sv */
// One transposed-form FIR tap; chained by the top level from the last tap down to tap 0.
`default_nettype none
`timescale 1ns/1ps

module firTap #(
    parameter eegFirPkg::weight_t Weight = '0
) (
    input logic clk,
    input logic reset,
    input eegFirPkg::sample_t tapSample,
    input logic productStrobe,
    input logic sumStrobe,
    input eegFirPkg::acc_t partialIn,
    output eegFirPkg::acc_t partialOut
);

    import eegFirPkg::*;

    product_t product;

    // ==========================================================
    // Weighted product
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            product <= '0;
        end
        else if (productStrobe)
        begin
            product <= product_t'(tapSample) * product_t'(Weight);
        end
    end

    // ==========================================================
    // Partial sum
    // ==========================================================

    // partialIn still holds the previous sample's sum from the next tap
    // when this register loads.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            partialOut <= '0;
        end
        else if (sumStrobe)
        begin
            partialOut <= acc_t'(product) + partialIn;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
eegFirPkg.sv
firIngress.sv
firTap.sv
firEgress.sv
eegFirFilter.sv
eegFirFilter_assertions.sv
eegFirFilter_tb.sv
